// ==== board_config.svh ====
//****************************************
// board configuration: clock dividers,
// beep length and synchronizer depth
//****************************************

`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// clock cycles each display digit stays lit
// small for simulation, raise for a real board clock
`define SCAN_DIV 4

// clock cycles per unit of tone half-period
// half-period is (byte+1) * TONE_STEP
`define TONE_STEP 2

// beep length in clock cycles
`define BEEP_CYCLES 2000

// depth of the PS/2 input synchronizers
`define SYNC_STAGES 2

`endif

// ==== ps2_pkg.sv ====
//****************************************
// PS/2 receiver types
//****************************************

package ps2_pkg;

	// one received scan byte
	typedef logic [7:0] ps2_byte_t;

	// position within the 11-bit frame
	typedef logic [3:0] ps2_bitcnt_t;

	// receiver FSM
	typedef enum logic [1:0] {
		rx_idle,	// waiting for a start bit
		rx_shift,	// data, parity and stop
		rx_finish	// frame check and strobe
	} ps2_state_e;

endpackage

// ==== disp_pkg.sv ====
//****************************************
// seven-segment display types
//****************************************

package disp_pkg;

	// active digit, 0 is the rightmost
	typedef logic [2:0] digit_idx_t;

	// one hex digit
	typedef logic [3:0] nibble_t;

	// bit 0..6 = segments a..g, bit 7 = decimal point
	// all active low
	typedef logic [7:0] seg_pat_t;

	// four newest bytes, newest in [7:0]
	typedef logic [31:0] disp_hist_t;

endpackage

// ==== ps2_rx.sv ====
//****************************************
// PS/2 device-to-host frame receiver
// with odd parity and stop bit check
//****************************************

`timescale 1ns/1ps
`include "board_config.svh"

module ps2_rx import ps2_pkg::*; (
	input  logic      clock,
	input  logic      rst_n_i,
	input  logic      ps2_clk_i,
	input  logic      ps2_data_i,
	input  logic      inhibit_i,
	output ps2_byte_t rx_byte_o,
	output logic      byte_valid_o,
	output logic      parity_err_o
);

	logic [`SYNC_STAGES-1:0] clk_sync;
	logic [`SYNC_STAGES-1:0] data_sync;
	logic                    clk_s;
	logic                    data_s;
	logic                    clk_prev_q;
	logic                    clk_fall;
	logic                    frame_ok;
	logic [9:0]              frame_q;	// stop, parity, data[7:0]
	ps2_state_e              state_q;
	ps2_bitcnt_t             bit_cnt_q;

	assign clk_s    = clk_sync[`SYNC_STAGES-1];
	assign data_s   = data_sync[`SYNC_STAGES-1];
	assign clk_fall = clk_prev_q & ~clk_s;

	// stop must be 1, data plus parity must hold an odd count of ones
	assign frame_ok  = frame_q[9] & (^frame_q[8:0]);
	assign rx_byte_o = frame_q[7:0];

	// lines idle high
	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			clk_sync   <= '1;
			data_sync  <= '1;
			clk_prev_q <= 1'b1;
		end else begin
			clk_sync   <= {clk_sync[`SYNC_STAGES-2:0], ps2_clk_i};
			data_sync  <= {data_sync[`SYNC_STAGES-2:0], ps2_data_i};
			clk_prev_q <= clk_s;
		end
	end

	// LSB first, so shift in from the top
	always_ff @(posedge clock) begin
		if (state_q == rx_shift && clk_fall && !inhibit_i)
			frame_q <= {data_s, frame_q[9:1]};
	end

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			state_q      <= rx_idle;
			bit_cnt_q    <= '0;
			byte_valid_o <= 1'b0;
			parity_err_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			parity_err_o <= 1'b0;
			if (inhibit_i) begin
				state_q <= rx_idle;	// abort, clock is held low
			end else begin
				case (state_q)
					rx_idle: begin
						if (clk_fall && !data_s) begin	// start bit
							bit_cnt_q <= 4'd1;
							state_q   <= rx_shift;
						end
					end
					rx_shift: begin
						if (clk_fall) begin
							if (bit_cnt_q == 4'd10)
								state_q <= rx_finish;	// stop bit taken
							else
								bit_cnt_q <= bit_cnt_q + 4'd1;
						end
					end
					rx_finish: begin
						byte_valid_o <= frame_ok;
						parity_err_o <= ~frame_ok;
						state_q      <= rx_idle;
					end
					default: state_q <= rx_idle;
				endcase
			end
		end
	end

endmodule

// ==== seg_scan.sv ====
//****************************************
// eight-digit seven-segment multiplexer
// showing the byte history in hex
//****************************************

`timescale 1ns/1ps
`include "board_config.svh"

module seg_scan import disp_pkg::*; (
	input  logic       clock,
	input  logic       rst_n_i,
	input  disp_hist_t hist_i,
	output logic [7:0] char_o,	// one-hot, active low
	output seg_pat_t   seg_o
);

	localparam int DIV_W = $clog2(`SCAN_DIV) + 1;

	logic [DIV_W-1:0] div_q;
	logic             tick;
	digit_idx_t       digit_q;
	digit_idx_t       digit_nxt;
	nibble_t          nib;

	// active low, dp off
	function automatic seg_pat_t hex_to_seg(input nibble_t n);
		case (n)
			4'h0: hex_to_seg = 8'hC0;
			4'h1: hex_to_seg = 8'hF9;
			4'h2: hex_to_seg = 8'hA4;
			4'h3: hex_to_seg = 8'hB0;
			4'h4: hex_to_seg = 8'h99;
			4'h5: hex_to_seg = 8'h92;
			4'h6: hex_to_seg = 8'h82;
			4'h7: hex_to_seg = 8'hF8;
			4'h8: hex_to_seg = 8'h80;
			4'h9: hex_to_seg = 8'h90;
			4'hA: hex_to_seg = 8'h88;
			4'hB: hex_to_seg = 8'h83;
			4'hC: hex_to_seg = 8'hC6;
			4'hD: hex_to_seg = 8'hA1;
			4'hE: hex_to_seg = 8'h86;
			default: hex_to_seg = 8'h8E;
		endcase
	endfunction

	assign tick      = (div_q == DIV_W'(`SCAN_DIV - 1));
	assign digit_nxt = digit_q + 3'd1;
	assign nib       = hist_i[{digit_nxt, 2'b00} +: 4];	// digit 0 = low nibble

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			div_q   <= '0;
			digit_q <= 3'd7;	// first tick lights digit 0
			char_o  <= 8'hFF;
			seg_o   <= 8'hFF;
		end else if (tick) begin
			div_q   <= '0;
			digit_q <= digit_nxt;
			char_o  <= ~(8'h01 << digit_nxt);
			seg_o   <= hex_to_seg(nib);
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

endmodule

// ==== tone_gen.sv ====
//****************************************
// square-wave beeper, pitch set per start
//****************************************

`timescale 1ns/1ps
`include "board_config.svh"

module tone_gen import ps2_pkg::*; (
	input  logic      clock,
	input  logic      rst_n_i,
	input  logic      start_i,
	input  ps2_byte_t pitch_i,
	output logic      level_o
);

	localparam int HALF_W = 9 + $clog2(`TONE_STEP + 1);
	localparam int BEEP_W = $clog2(`BEEP_CYCLES + 1);

	ps2_byte_t         pitch_q;
	logic [HALF_W-1:0] half_q;
	logic [HALF_W-1:0] half_lim;
	logic [BEEP_W-1:0] beep_q;	// cycles left, 0 when silent

	// half-period of (pitch+1)*TONE_STEP cycles
	assign half_lim = (HALF_W'(pitch_q) + HALF_W'(1)) * HALF_W'(`TONE_STEP) - HALF_W'(1);

	always_ff @(posedge clock) begin
		if (start_i)
			pitch_q <= pitch_i;
	end

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			level_o <= 1'b1;
			half_q  <= '0;
			beep_q  <= '0;
		end else if (start_i) begin	// also restarts a running beep
			level_o <= 1'b0;
			half_q  <= '0;
			beep_q  <= BEEP_W'(`BEEP_CYCLES);
		end else if (beep_q != '0) begin
			beep_q <= beep_q - 1'b1;
			if (beep_q == BEEP_W'(1)) begin
				level_o <= 1'b1;	// done, pin floats
			end else if (half_q == half_lim) begin
				half_q  <= '0;
				level_o <= ~level_o;
			end else begin
				half_q <= half_q + 1'b1;
			end
		end
	end

endmodule

// ==== core_unit.sv ====
//****************************************
// keyboard console core: receiver, byte
// history, display, beeper, error latch
//****************************************

`timescale 1ns/1ps

module core_unit import ps2_pkg::*, disp_pkg::*; (
	input  logic       clock,
	input  logic       rst_n_i,
	input  logic       ps2_clk_i,
	input  logic       ps2_data_i,
	input  logic       hold_i,
	output logic       ps2_clk_o,
	output logic       ps2_clk_d,
	output logic       aud_level_o,
	output logic [7:0] char_o,
	output seg_pat_t   seg_o,
	output logic       status_o
);

	ps2_byte_t  rx_byte;
	logic       byte_valid;
	logic       parity_err;
	disp_hist_t hist_q;
	logic       err_q;

	// inhibit the keyboard by pulling its clock low
	assign ps2_clk_o = 1'b0;
	assign ps2_clk_d = hold_i;
	assign status_o  = err_q;

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			hist_q <= '0;
			err_q  <= 1'b0;
		end else begin
			if (byte_valid) begin
				hist_q <= {hist_q[23:0], rx_byte};	// oldest byte falls out
				err_q  <= 1'b0;
			end else if (parity_err) begin
				err_q <= 1'b1;
			end
		end
	end

	ps2_rx u_rx (
		.clock        (clock),
		.rst_n_i      (rst_n_i),
		.ps2_clk_i    (ps2_clk_i),
		.ps2_data_i   (ps2_data_i),
		.inhibit_i    (hold_i),
		.rx_byte_o    (rx_byte),
		.byte_valid_o (byte_valid),
		.parity_err_o (parity_err)
	);

	seg_scan u_scan (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.hist_i  (hist_q),
		.char_o  (char_o),
		.seg_o   (seg_o)
	);

	tone_gen u_tone (
		.clock   (clock),
		.rst_n_i (rst_n_i),
		.start_i (byte_valid),
		.pitch_i (rx_byte),
		.level_o (aud_level_o)
	);

endmodule

// ==== board_top.sv ====
//****************************************
// pad wrapper: tristate and open-drain
// pins around the console core
//****************************************

`timescale 1ns/1ps

module board_top (
	input  logic       clock,
	input  logic       rst_n_i,
	inout  wire        ps2_clk,
	inout  wire        ps2_data,
	inout  wire        aud_mono_out,	// open drain, pulled up on the board
	input  logic       hold_i,
	output logic [7:0] seg_outCharBit_o,
	output logic [7:0] seg_outSegBit_o,
	output logic       dbg_status_o
);

	wire ps2_clk_i;
	wire ps2_data_i;
	wire ps2_clk_o;
	wire ps2_clk_d;
	wire aud_level;

	assign ps2_clk    = ps2_clk_d ? ps2_clk_o : 1'bz;
	assign ps2_clk_i  = ps2_clk;
	assign ps2_data_i = ps2_data;	// data is never driven

	// high level floats, low level pulls down
	assign aud_mono_out = aud_level ? 1'bz : 1'b0;

	core_unit u_core (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.ps2_clk_i   (ps2_clk_i),
		.ps2_data_i  (ps2_data_i),
		.hold_i      (hold_i),
		.ps2_clk_o   (ps2_clk_o),
		.ps2_clk_d   (ps2_clk_d),
		.aud_level_o (aud_level),
		.char_o      (seg_outCharBit_o),
		.seg_o       (seg_outSegBit_o),
		.status_o    (dbg_status_o)
	);

endmodule

// ==== tb_board_top.sv ====
//****************************************
// testbench for the keyboard console,
// emulates a PS/2 keyboard and checks pins
//****************************************

`timescale 1ns/1ps
`include "board_config.svh"

module tb_board_top import ps2_pkg::*, disp_pkg::*; ();

	localparam int HALF_BIT   = 20;	// keyboard half bit in clock cycles
	localparam int NUM_FRAMES = 9;
	localparam int NUM_BEEPS  = 7;
	localparam int SCAN_WAIT  = 3 * 8 * `SCAN_DIV;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * 11 * 2 * HALF_BIT
		+ NUM_BEEPS * (`BEEP_CYCLES + 512 * `TONE_STEP) + 10000;

	// gfedcba, active low, dp off
	localparam seg_pat_t HEX_SEG [16] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
		8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
	};

	logic        clock;
	logic        rst_n_i;
	logic        hold_i;
	logic        kb_clk_low;	// keyboard pulls its clock line
	logic        kb_data_low;
	wire         ps2_clk;
	wire         ps2_data;
	wire         aud_mono_out;
	logic [7:0]  char_sel;
	seg_pat_t    seg_pat;
	logic        status;
	int          err_cnt;
	int          check_cnt;
	int unsigned cycle_cnt = 0;
	disp_hist_t  exp_hist;

	pullup (ps2_clk);
	pullup (ps2_data);
	pullup (aud_mono_out);

	// keyboard side is open drain too
	assign ps2_clk  = kb_clk_low ? 1'b0 : 1'bz;
	assign ps2_data = kb_data_low ? 1'b0 : 1'bz;

	board_top u_board_top (
		.clock            (clock),
		.rst_n_i          (rst_n_i),
		.ps2_clk          (ps2_clk),
		.ps2_data         (ps2_data),
		.aud_mono_out     (aud_mono_out),
		.hold_i           (hold_i),
		.seg_outCharBit_o (char_sel),
		.seg_outSegBit_o  (seg_pat),
		.dbg_status_o     (status)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock)
		cycle_cnt <= cycle_cnt + 1;

	task automatic check_level(input string name, input logic actual, input logic expected);
		check_cnt++;
		if (actual !== expected) begin
			err_cnt++;
			$display("error %s: got %h expected %h", name, actual, expected);
		end
	endtask

	// wait for the digit to come round again so it shows the current history
	task automatic check_seg(input digit_idx_t idx, input seg_pat_t expected);
		logic [7:0] sel;
		int         waited;
		sel    = ~(8'h01 << idx);
		waited = 0;
		while (char_sel === sel && waited < SCAN_WAIT) begin
			@(negedge clock);
			waited++;
		end
		while (char_sel !== sel && waited < SCAN_WAIT) begin
			@(negedge clock);
			waited++;
		end
		check_cnt++;
		if (char_sel !== sel) begin
			err_cnt++;
			$display("display digit %0d was never selected", idx);
		end else if (seg_pat !== expected) begin
			err_cnt++;
			$display("error seg_outSegBit_o digit %0d: got %h expected %h",
				idx, seg_pat, expected);
		end
	endtask

	// low phase first, then high, both counted on falling clock edges
	task automatic check_half_period(input ps2_byte_t b);
		int   expected;
		int   count;
		int   phase;
		logic lvl;
		expected = (int'(b) + 1) * `TONE_STEP;
		for (phase = 0; phase < 2; phase++) begin
			lvl   = (phase == 1);
			count = 0;
			while (aud_mono_out === lvl && count <= expected + 2) begin
				count++;
				@(negedge clock);
			end
			check_cnt++;
			if (count < expected - 1 || count > expected + 1) begin
				err_cnt++;
				$display("error aud_mono_out half-period: got %h expected %h",
					count, expected);
			end
		end
	endtask

	task automatic check_display();
		int idx;
		for (idx = 0; idx < 8; idx++)
			check_seg(digit_idx_t'(idx), HEX_SEG[exp_hist[idx*4 +: 4]]);
	endtask

	task automatic send_frame(input ps2_byte_t b, input logic bad_parity);
		logic [10:0] frame;
		logic        par;
		int          i;
		par = ~(^b);	// odd parity
		if (bad_parity)
			par = ~par;
		frame = {1'b1, par, b, 1'b0};
		@(posedge clock);
		for (i = 0; i < 11; i++) begin
			kb_data_low <= ~frame[i];
			repeat (HALF_BIT) @(posedge clock);
			kb_clk_low <= 1'b1;
			repeat (HALF_BIT) @(posedge clock);
			kb_clk_low <= 1'b0;
		end
		kb_data_low <= 1'b0;
		repeat (HALF_BIT) @(posedge clock);
	endtask

	task automatic wait_audio_start(output logic found);
		int n;
		found = 1'b0;
		for (n = 0; n < 11 * 2 * HALF_BIT + 40 && !found; n++) begin
			@(negedge clock);
			found = (aud_mono_out === 1'b0);
		end
	endtask

	task automatic check_beep_end(input int unsigned start_cycle, input ps2_byte_t b);
		int n;
		int window;
		window = 2 * (int'(b) + 1) * `TONE_STEP + 4;
		while (cycle_cnt < start_cycle + `BEEP_CYCLES + 2)
			@(negedge clock);
		n = 0;
		while (n < window && aud_mono_out === 1'b1) begin
			@(negedge clock);
			n++;
		end
		check_level("aud_mono_out", aud_mono_out, 1'b1);
	endtask

	// one accepted byte: beep pitch, beep end, error latch cleared
	task automatic send_good_byte(input ps2_byte_t b);
		logic        found;
		int unsigned start_cycle;
		found       = 1'b0;
		start_cycle = cycle_cnt;
		fork
			send_frame(b, 1'b0);
			begin
				wait_audio_start(found);
				start_cycle = cycle_cnt;
				if (found && 2 * (int'(b) + 1) * `TONE_STEP + 4 < `BEEP_CYCLES)
					check_half_period(b);
			end
		join
		if (!found) begin
			check_cnt++;
			err_cnt++;
			$display("no beep started after the frame for byte %h", b);
		end
		exp_hist = {exp_hist[23:0], b};
		check_level("dbg_status_o", status, 1'b0);
		check_beep_end(start_cycle, b);
	endtask

	task automatic test_reset_state();
		@(negedge clock);
		check_level("dbg_status_o", status, 1'b0);
		check_level("aud_mono_out", aud_mono_out, 1'b1);
		check_level("ps2_clk", ps2_clk, 1'b1);
		check_display();
	endtask

	task automatic test_history();
		int n;
		for (n = 0; n < 4; n++)
			send_good_byte(ps2_byte_t'($urandom()));
		check_display();
		send_good_byte(ps2_byte_t'($urandom()));	// oldest drops out
		check_display();
	endtask

	task automatic test_parity_error();
		send_frame(ps2_byte_t'($urandom()), 1'b1);
		@(negedge clock);
		check_level("dbg_status_o", status, 1'b1);
		check_level("aud_mono_out", aud_mono_out, 1'b1);
		check_display();
		send_good_byte(ps2_byte_t'($urandom()));
		check_display();
	endtask

	// hold rises in the middle of a frame, so the receiver has to drop it
	task automatic test_hold();
		fork
			send_frame(ps2_byte_t'($urandom()), 1'b0);	// keyboard ignores the inhibit
			begin
				repeat (5 * 2 * HALF_BIT + HALF_BIT / 2) @(posedge clock);
				hold_i <= 1'b1;
				repeat (3) @(negedge clock);
				check_level("ps2_clk", ps2_clk, 1'b0);
			end
		join
		@(negedge clock);
		check_level("ps2_clk", ps2_clk, 1'b0);
		check_level("aud_mono_out", aud_mono_out, 1'b1);
		check_level("dbg_status_o", status, 1'b0);
		check_display();
		@(posedge clock);
		hold_i <= 1'b0;
		repeat (4) @(negedge clock);
		check_level("ps2_clk", ps2_clk, 1'b1);
		send_good_byte(ps2_byte_t'($urandom()));
		check_display();
	endtask

	initial begin
		rst_n_i     = 1'b0;
		hold_i      = 1'b0;
		kb_clk_low  = 1'b0;
		kb_data_low = 1'b0;
		err_cnt     = 0;
		check_cnt   = 0;
		exp_hist    = '0;
		void'($urandom(17807));
		repeat (10) @(posedge clock);
		rst_n_i <= 1'b1;
		test_reset_state();
		test_history();
		test_parity_error();
		test_hold();
		$display("checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
ps2_pkg.sv
disp_pkg.sv
ps2_rx.sv
seg_scan.sv
tone_gen.sv
core_unit.sv
board_top.sv
tb_board_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_board_top
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

SOURCES = $(shell grep -v '^+' $(FILELIST)) board_config.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
